// File: hw/lcd_params.svh
`ifndef LCD_PARAMS_SVH
`define LCD_PARAMS_SVH

// Command FIFO entries, power of two
`define LCD_FIFO_DEPTH 8

// Bus write cycle timing in CLOCK cycles
`define LCD_SETUP_CYCLES 2 // RS and D settle before EN rises
`define LCD_EN_HIGH_CYCLES 4 // EN pulse width
`define LCD_SHORT_WAIT_CYCLES 6 // Ordinary instruction or data write
`define LCD_LONG_WAIT_CYCLES 40 // Clear and home take much longer

// Fixed line 1 content, exactly 16 characters
`define LCD_LINE1_TEXT "Hello LCD1602   "

// Frame counter runs 0 up to this value then wraps, keep below 100
`define LCD_COUNT_MAX 16

`endif

// File: hw/lcdPkg.sv
`default_nettype none

package lcdPkg;

	// Selects the RS level of a bus write
	typedef enum logic
	{
		cmdInstr = 1'b0, // RS low, instruction register
		cmdData = 1'b1 // RS high, DDRAM data
	} lcdCmdKind_t;

	// Screen writer phases
	typedef enum logic [2:0]
	{
		wrInit, // Power-up instruction sequence
		wrLine1Addr, // Set DDRAM address 0x00
		wrLine1Char,
		wrLine2Addr, // Set DDRAM address 0x40
		wrLine2Char,
		wrCountUpdate // One idle cycle per frame
	} writerState_t;

endpackage

`default_nettype wire

// File: hw/lcdCmdIf.sv
`timescale 1ns/100ps
`default_nettype none

// One LCD command with valid/ready handshake
interface lcdCmdIf;

	logic valid; // Source offers a command
	lcdPkg::lcdCmdKind_t kind; // Instruction or data
	logic [7:0] code; // Instruction byte or character code
	logic ready; // Sink can take it this cycle

	// Holds valid, kind and code until the transfer
	modport source
	(
		output valid,
		output kind,
		output code,
		input ready
	);

	modport sink
	(
		input valid,
		input kind,
		input code,
		output ready
	);

endinterface

`default_nettype wire

// File: hw/lcdScreenWriter.sv
`timescale 1ns/100ps
`default_nettype none
`include "lcd_params.svh"

module lcdScreenWriter
(
	input logic CLOCK,
	input logic RST_n,
	lcdCmdIf.source cmdOut
);

	localparam int countWidth = $clog2(`LCD_COUNT_MAX + 1);
	localparam logic [127:0] line1Text = `LCD_LINE1_TEXT;

	lcdPkg::writerState_t state;
	logic running; // Low only in the first cycle after reset
	logic [1:0] initIdx; // Step in the init sequence
	logic [3:0] charIdx; // Column within the current line
	logic [countWidth-1:0] count; // Frame counter shown on line 2
	logic [countWidth-1:0] tensVal;
	logic [countWidth-1:0] onesVal;
	logic [127:0] line2Text;
	logic xfer;

	// Decimal digits with leading zero
	assign tensVal = count / countWidth'(10);
	assign onesVal = count % countWidth'(10);
	assign line2Text = {"Count: ", 8'h30 + 8'(tensVal), 8'h30 + 8'(onesVal), "       "};

	assign cmdOut.valid = running && (state != lcdPkg::wrCountUpdate);
	assign xfer = cmdOut.valid && cmdOut.ready;

	// Command for the current position
	always_comb
	begin
		cmdOut.kind = lcdPkg::cmdInstr;
		cmdOut.code = 8'h00;
		case (state)
			lcdPkg::wrInit:
			begin
				case (initIdx)
					2'd0: cmdOut.code = 8'h38; // 8-bit bus, two lines, 5x8 font
					2'd1: cmdOut.code = 8'h0C; // Display on, cursor off
					2'd2: cmdOut.code = 8'h06; // Increment, no shift
					default: cmdOut.code = 8'h01; // Clear
				endcase
			end
			lcdPkg::wrLine1Addr: cmdOut.code = 8'h80;
			lcdPkg::wrLine1Char:
			begin
				cmdOut.kind = lcdPkg::cmdData;
				cmdOut.code = line1Text[{~charIdx, 3'b000} +: 8]; // Leftmost char is MSB byte
			end
			lcdPkg::wrLine2Addr: cmdOut.code = 8'hC0;
			lcdPkg::wrLine2Char:
			begin
				cmdOut.kind = lcdPkg::cmdData;
				cmdOut.code = line2Text[{~charIdx, 3'b000} +: 8];
			end
			default: cmdOut.code = 8'h00; // Count update, nothing offered
		endcase
	end

	// Position only moves on a transfer
	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
		begin
			state <= lcdPkg::wrInit;
			running <= 1'b0;
			initIdx <= 2'd0;
			charIdx <= 4'd0;
			count <= '0;
		end
		else
		begin
			running <= 1'b1;
			case (state)
				lcdPkg::wrInit:
				begin
					if (xfer)
					begin
						initIdx <= initIdx + 2'd1;
						if (initIdx == 2'd3)
							state <= lcdPkg::wrLine1Addr;
					end
				end
				lcdPkg::wrLine1Addr:
				begin
					if (xfer)
						state <= lcdPkg::wrLine1Char;
				end
				lcdPkg::wrLine1Char:
				begin
					if (xfer)
					begin
						charIdx <= charIdx + 4'd1; // Wraps to 0 after column 15
						if (charIdx == 4'd15)
							state <= lcdPkg::wrLine2Addr;
					end
				end
				lcdPkg::wrLine2Addr:
				begin
					if (xfer)
						state <= lcdPkg::wrLine2Char;
				end
				lcdPkg::wrLine2Char:
				begin
					if (xfer)
					begin
						charIdx <= charIdx + 4'd1;
						if (charIdx == 4'd15)
							state <= lcdPkg::wrCountUpdate;
					end
				end
				default:
				begin
					// End of frame
					if (count == countWidth'(`LCD_COUNT_MAX))
						count <= '0;
					else
						count <= count + countWidth'(1);
					state <= lcdPkg::wrLine1Addr;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/lcdCmdFifo.sv
`timescale 1ns/100ps
`default_nettype none
`include "lcd_params.svh"

module lcdCmdFifo
(
	input logic CLOCK,
	input logic RST_n,
	lcdCmdIf.sink cmdIn,
	lcdCmdIf.source cmdOut
);

	localparam int depth = `LCD_FIFO_DEPTH;
	localparam int ptrWidth = $clog2(depth);

	lcdPkg::lcdCmdKind_t kindMem [depth];
	logic [7:0] codeMem [depth];
	logic [ptrWidth-1:0] wrPtr; // Wraps on its own, depth is a power of two
	logic [ptrWidth-1:0] rdPtr;
	logic [ptrWidth:0] occupancy;
	logic push;
	logic pop;

	assign cmdIn.ready = (occupancy != (ptrWidth + 1)'(depth));
	assign cmdOut.valid = (occupancy != '0);
	assign cmdOut.kind = kindMem[rdPtr]; // Head entry, visible the cycle after its write
	assign cmdOut.code = codeMem[rdPtr];

	assign push = cmdIn.valid && cmdIn.ready;
	assign pop = cmdOut.valid && cmdOut.ready;

	// Storage
	always_ff @(posedge CLOCK)
	begin
		if (push)
		begin
			kindMem[wrPtr] <= cmdIn.kind;
			codeMem[wrPtr] <= cmdIn.code;
		end
	end

	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			occupancy <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + ptrWidth'(1);
			if (pop)
				rdPtr <= rdPtr + ptrWidth'(1);
			case ({push, pop})
				2'b10: occupancy <= occupancy + (ptrWidth + 1)'(1);
				2'b01: occupancy <= occupancy - (ptrWidth + 1)'(1);
				default: occupancy <= occupancy; // Both or neither
			endcase
		end
	end

	// Occupancy bounded by depth
	// An underflow would wrap far above depth as well
	assert property (@(posedge CLOCK) disable iff (!RST_n)
		occupancy <= (ptrWidth + 1)'(depth));

	// Head held under back-pressure from the driver
	assert property (@(posedge CLOCK) disable iff (!RST_n)
		(cmdOut.valid && !cmdOut.ready) |=> ($stable(cmdOut.kind) && $stable(cmdOut.code)));

endmodule

`default_nettype wire

// File: hw/lcdBusDriver.sv
`timescale 1ns/100ps
`default_nettype none
`include "lcd_params.svh"

module lcdBusDriver
(
	input logic CLOCK,
	input logic RST_n,
	lcdCmdIf.sink cmdIn,
	output logic lcdRs,
	output logic lcdRw,
	output logic lcdEn,
	output logic [7:0] lcdData
);

	localparam int cntWidth = $clog2(`LCD_LONG_WAIT_CYCLES + 1);

	typedef enum logic [1:0]
	{
		phIdle,
		phSetup, // RS and D settling
		phEnable, // EN high
		phWait // Controller executing
	} busPhase_t;

	busPhase_t phase;
	logic [cntWidth-1:0] phaseCnt; // Cycles left in this phase, minus one
	lcdPkg::lcdCmdKind_t rsKind;
	logic [7:0] dataReg;
	logic longWait;

	assign cmdIn.ready = (phase == phIdle);
	assign lcdEn = (phase == phEnable);
	assign lcdRw = 1'b0; // Write only, no busy flag polling
	assign lcdRs = (rsKind == lcdPkg::cmdData);
	assign lcdData = dataReg;

	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
		begin
			phase <= phIdle;
			phaseCnt <= '0;
			rsKind <= lcdPkg::cmdInstr;
			dataReg <= 8'h00;
			longWait <= 1'b0;
		end
		else
		begin
			case (phase)
				phIdle:
				begin
					if (cmdIn.valid)
					begin
						rsKind <= cmdIn.kind;
						dataReg <= cmdIn.code;
						// Clear and home need the long execution time
						longWait <= (cmdIn.kind == lcdPkg::cmdInstr) &&
							(cmdIn.code == 8'h01 || cmdIn.code == 8'h02);
						phaseCnt <= cntWidth'(`LCD_SETUP_CYCLES - 1);
						phase <= phSetup;
					end
				end
				phSetup:
				begin
					if (phaseCnt == '0)
					begin
						phaseCnt <= cntWidth'(`LCD_EN_HIGH_CYCLES - 1);
						phase <= phEnable;
					end
					else
						phaseCnt <= phaseCnt - cntWidth'(1);
				end
				phEnable:
				begin
					if (phaseCnt == '0)
					begin
						phaseCnt <= longWait ? cntWidth'(`LCD_LONG_WAIT_CYCLES - 1)
							: cntWidth'(`LCD_SHORT_WAIT_CYCLES - 1);
						phase <= phWait;
					end
					else
						phaseCnt <= phaseCnt - cntWidth'(1);
				end
				default:
				begin
					if (phaseCnt == '0)
						phase <= phIdle; // Ready again next cycle
					else
						phaseCnt <= phaseCnt - cntWidth'(1);
				end
			endcase
		end
	end

	// Bus held from setup through the whole pulse
	assert property (@(posedge CLOCK) disable iff (!RST_n)
		lcdEn |-> ($stable(lcdData) && $stable(lcdRs)));

endmodule

`default_nettype wire

// File: hw/lcdDisplayTop.sv
`timescale 1ns/100ps
`default_nettype none

module lcdDisplayTop
(
	input logic CLOCK,
	input logic RST_n,
	output logic lcdRs, // H data, L instruction
	output logic lcdRw, // Always write
	output logic lcdEn,
	output logic [7:0] lcdData
);

	lcdCmdIf writerToFifo();
	lcdCmdIf fifoToDriver();

	// Init sequence and frame content
	lcdScreenWriter lcdScreenWriter_i
	(
		.CLOCK(CLOCK),
		.RST_n(RST_n),
		.cmdOut(writerToFifo.source)
	);

	// Absorbs writer bursts while the bus is busy
	lcdCmdFifo lcdCmdFifo_i
	(
		.CLOCK(CLOCK),
		.RST_n(RST_n),
		.cmdIn(writerToFifo.sink),
		.cmdOut(fifoToDriver.source)
	);

	lcdBusDriver lcdBusDriver_i
	(
		.CLOCK(CLOCK),
		.RST_n(RST_n),
		.cmdIn(fifoToDriver.sink),
		.lcdRs(lcdRs),
		.lcdRw(lcdRw),
		.lcdEn(lcdEn),
		.lcdData(lcdData)
	);

endmodule

`default_nettype wire

// File: verification/lcdDisplayTb.sv
`timescale 1ns/100ps
`default_nettype none
`include "lcd_params.svh"

module lcdDisplayTb;

	localparam int busTimeout = 4 * (`LCD_SETUP_CYCLES + `LCD_EN_HIGH_CYCLES
		+ `LCD_LONG_WAIT_CYCLES) + `LCD_FIFO_DEPTH + 50;
	localparam logic [127:0] line1Text = `LCD_LINE1_TEXT; // Leftmost char in top byte
	localparam logic [55:0] countLabel = "Count: ";

	logic CLOCK;
	logic RST_n;
	logic lcdRs;
	logic lcdRw;
	logic lcdEn;
	logic [7:0] lcdData;

	int errorCount;
	logic timedOut; // Set once a wait ran out, later checks are skipped
	logic havePrev; // A write was seen, so the next gap can be measured
	logic prevLong; // Last write was clear or home

	lcdDisplayTop lcdDisplayTop_i
	(
		.CLOCK(CLOCK),
		.RST_n(RST_n),
		.lcdRs(lcdRs),
		.lcdRw(lcdRw),
		.lcdEn(lcdEn),
		.lcdData(lcdData)
	);

	initial
	begin
		CLOCK = 1'b0;
		forever #5 CLOCK = ~CLOCK; // 10 ns period
	end

	task automatic compareKind(input string name, input lcdPkg::lcdCmdKind_t expected,
		input lcdPkg::lcdCmdKind_t actual);
		if (actual !== expected)
		begin
			$display("ERROR at %0t: %s expected %s actual %s", $time, name, expected.name(),
				actual.name());
			errorCount++;
		end
	endtask

	task automatic compareCode(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected)
		begin
			$display("ERROR at %0t: %s expected 0x%02h actual 0x%02h", $time, name, expected,
				actual);
			errorCount++;
		end
	endtask

	task automatic compareCycles(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("ERROR at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	// Pulse width, gap since the last pulse and RW level of one write
	task automatic checkBusTiming(input lcdPkg::lcdCmdKind_t kind, input logic [7:0] code,
		input int lowCnt, input int highCnt, input logic rwHigh);
		int minGap;
		compareCycles("lcdEn high cycles", `LCD_EN_HIGH_CYCLES, highCnt);
		if (havePrev)
		begin
			minGap = prevLong ? `LCD_LONG_WAIT_CYCLES : `LCD_SHORT_WAIT_CYCLES;
			if (lowCnt < minGap)
			begin
				$display("ERROR at %0t: lcdEn low gap expected at least %0d actual %0d",
					$time, minGap, lowCnt);
				errorCount++;
			end
		end
		if (rwHigh)
		begin
			$display("lcdRw went high around the write that ended at %0t", $time);
			errorCount++;
		end
		havePrev = 1'b1;
		prevLong = (kind == lcdPkg::cmdInstr) && (code == 8'h01 || code == 8'h02); // Clear, home
	endtask

	// Entered just after a falling clock edge with EN low, returns at the same point
	task automatic captureWrite(output lcdPkg::lcdCmdKind_t kind, output logic [7:0] code);
		int lowCnt;
		int highCnt;
		logic rwHigh;
		lowCnt = 0;
		highCnt = 0;
		rwHigh = 1'b0;
		kind = lcdPkg::cmdInstr;
		code = 8'h00;
		if (timedOut)
			return;
		while (!lcdEn && lowCnt < busTimeout)
		begin
			lowCnt++;
			rwHigh |= lcdRw;
			@(negedge CLOCK); // Mid-cycle, outputs settled
		end
		if (!lcdEn)
		begin
			$display("No EN pulse started within %0d cycles, stopped at %0t", busTimeout, $time);
			timedOut = 1'b1;
			return;
		end
		kind = lcdPkg::lcdCmdKind_t'(lcdRs);
		code = lcdData;
		while (lcdEn && highCnt < busTimeout)
		begin
			highCnt++;
			rwHigh |= lcdRw;
			compareCode("lcdData while EN high", code, lcdData);
			@(negedge CLOCK);
		end
		if (lcdEn)
		begin
			$display("EN stayed high for %0d cycles, stopped at %0t", busTimeout, $time);
			timedOut = 1'b1;
			return;
		end
		checkBusTiming(kind, code, lowCnt, highCnt, rwHigh);
	endtask

	task automatic expectWrite(input string what, input lcdPkg::lcdCmdKind_t expectedKind,
		input logic [7:0] expectedCode);
		lcdPkg::lcdCmdKind_t kind;
		logic [7:0] code;
		captureWrite(kind, code);
		if (!timedOut)
		begin
			compareKind({"lcdRs ", what}, expectedKind, kind);
			compareCode({"lcdData ", what}, expectedCode, code);
		end
	endtask

	// Expected line 2 character at one column
	function automatic logic [7:0] line2Char(input int count, input int col);
		if (col < 7)
			return countLabel[8 * (6 - col) +: 8];
		else if (col == 7)
			return 8'h30 + 8'(count / 10); // Tens, leading zero
		else if (col == 8)
			return 8'h30 + 8'(count % 10);
		else
			return 8'h20;
	endfunction

	task automatic checkInit();
		logic [7:0] initCodes [4];
		initCodes = '{8'h38, 8'h0C, 8'h06, 8'h01};
		for (int i = 0; i < 4 && !timedOut; i++)
			expectWrite($sformatf("init step %0d", i), lcdPkg::cmdInstr, initCodes[i]);
	endtask

	task automatic checkLine1();
		expectWrite("line 1 address", lcdPkg::cmdInstr, 8'h80);
		for (int col = 0; col < 16 && !timedOut; col++)
			expectWrite($sformatf("line 1 column %0d", col), lcdPkg::cmdData,
				line1Text[8 * (15 - col) +: 8]);
	endtask

	task automatic checkLine2(input int count);
		expectWrite("line 2 address", lcdPkg::cmdInstr, 8'hC0);
		for (int col = 0; col < 16 && !timedOut; col++)
			expectWrite($sformatf("line 2 column %0d count %0d", col, count), lcdPkg::cmdData,
				line2Char(count, col));
	endtask

	// Counter runs 00 up to the max, then shows 00 again
	task automatic checkCountWrap();
		int shown;
		for (int frame = 0; frame < `LCD_COUNT_MAX + 2 && !timedOut; frame++)
		begin
			shown = (frame > `LCD_COUNT_MAX) ? 0 : frame;
			checkLine1();
			checkLine2(shown);
		end
	endtask

	initial
	begin
		RST_n = 1'b0;
		errorCount = 0;
		timedOut = 1'b0;
		havePrev = 1'b0;
		prevLong = 1'b0;
		repeat (7) @(posedge CLOCK);
		@(negedge CLOCK);
		compareCode("lcdData in reset", 8'h00, lcdData);
		compareCycles("lcdEn in reset", 0, int'(lcdEn));
		compareCycles("lcdRs in reset", 0, int'(lcdRs));
		compareCycles("lcdRw in reset", 0, int'(lcdRw));
		@(posedge CLOCK); // Eighth edge in reset
		#2 RST_n = 1'b1;
		@(negedge CLOCK);
		checkInit();
		checkCountWrap();
		$display("Errors: %0d, timeout: %0d", errorCount, timedOut);
		if (errorCount == 0 && !timedOut)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/lcdPkg.sv
hw/lcdCmdIf.sv
hw/lcdScreenWriter.sv
hw/lcdCmdFifo.sv
hw/lcdBusDriver.sv
hw/lcdDisplayTop.sv
verification/lcdDisplayTb.sv

// File: run.sh
#!/bin/sh
# Build and run the LCD display testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module lcdDisplayTb -o lcdDisplayTb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/lcdDisplayTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Verdict comes from the log
if grep -q "Testbench failed" "$LOG"; then
	exit 1
fi
exit 0
